// ==== Makefile ====
TOP := sifhTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qx ">>> PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
source/sifhPkg.sv
source/frameSequencer.sv
source/sampleDecoder.sv
source/binHistogram.sv
source/peakFinder.sv
source/resultStreamer.sv
source/sifhTop.sv
test/clockGen.sv
test/sifhTb.sv

// ==== source/binHistogram.sv ====
module binHistogram
    import sifhPkg::*;
#(
    parameter int PIXELS  = 4,
    parameter int COUNT_W = 8,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               accept,
    input  logic               binHit,
    input  logic [PIX_W-1:0]   pixel,
    input  logic [BIN_W-1:0]   binIdx,
    input  logic               flush,
    input  logic               clearAll,
    output logic               countValid,
    output logic [PIX_W-1:0]   countPixel,
    output logic [BIN_W-1:0]   countBin,
    output logic [COUNT_W-1:0] countValue
);

    localparam int BINS = 2 ** BIN_W;

    // one histogram per pixel
    logic [COUNT_W-1:0] mem [PIXELS][BINS];
    logic               incr;
    logic [COUNT_W-1:0] nextCount;

    assign incr      = accept && binHit;
    // read straight from memory so back to back hits chain
    assign nextCount = mem[pixel][binIdx] + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            countValid <= 1'b0;
            for (int p = 0; p < PIXELS; p++) begin
                for (int b = 0; b < BINS; b++) begin
                    mem[p][b] <= '0;
                end
            end
        end else begin
            countValid <= incr;
            if (flush || clearAll) begin
                // whole memory in one cycle
                for (int p = 0; p < PIXELS; p++) begin
                    for (int b = 0; b < BINS; b++) begin
                        mem[p][b] <= '0;
                    end
                end
            end else if (incr) begin
                mem[pixel][binIdx] <= nextCount;
            end
        end
    end

    // new count and where it went, one cycle after the hit
    always_ff @(posedge clk) begin
        if (incr) begin
            countPixel <= pixel;
            countBin   <= binIdx;
            countValue <= nextCount;
        end
    end

endmodule

// ==== source/frameSequencer.sv ====
module frameSequencer #(
    parameter int PIXELS  = 4,
    parameter int SAMPLES = 8,
    parameter int ACQS    = 2,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             sampleValid,
    input  logic             readoutDone,
    output logic             sampleReady,
    output logic             accept,
    output logic [PIX_W-1:0] pixel,
    output logic             finePass,
    output logic             flush,
    output logic             startReadout,
    output logic             clearAll
);

    localparam int SMP_W  = (SAMPLES > 1) ? $clog2(SAMPLES) : 1;
    localparam int ACQ_W  = (ACQS > 1) ? $clog2(ACQS) : 1;
    localparam int STEP_W = $clog2(PIXELS + 2);

    // phase encodings
    localparam logic [2:0] PH_RUN     = 3'd0;
    localparam logic [2:0] PH_DRAIN   = 3'd1;
    localparam logic [2:0] PH_FLUSH   = 3'd2;
    localparam logic [2:0] PH_START   = 3'd3;
    localparam logic [2:0] PH_READOUT = 3'd4;
    localparam logic [2:0] PH_CLEAR   = 3'd5;

    logic [2:0]        phase;
    logic [STEP_W-1:0] stepCnt;
    logic [SMP_W-1:0]  sampleCnt;
    logic [ACQ_W-1:0]  acqCnt;
    logic              lastSample;
    logic              lastPixel;
    logic              lastAcq;
    logic              passEnd;

    // handshake and phase strobes
    assign sampleReady  = (phase == PH_RUN);
    assign accept       = sampleValid && sampleReady;
    assign flush        = (phase == PH_FLUSH);
    assign startReadout = (phase == PH_START);
    assign clearAll     = (phase == PH_CLEAR);

    assign lastSample = (sampleCnt == SMP_W'(SAMPLES - 1));
    assign lastPixel  = (pixel == PIX_W'(PIXELS - 1));
    assign lastAcq    = (acqCnt == ACQ_W'(ACQS - 1));
    // final sample of acquisitions x pixels x samples
    assign passEnd    = accept && lastSample && lastPixel && lastAcq;

    // nested counters, samples innermost
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            if (lastSample) begin
                sampleCnt <= '0;
                if (lastPixel) begin
                    pixel  <= '0;
                    acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // pass bit and the ready-low sequence between passes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            phase    <= PH_RUN;
            stepCnt  <= '0;
            finePass <= 1'b0;
        end else begin
            case (phase)
                PH_RUN: begin
                    if (passEnd) begin
                        phase    <= PH_DRAIN;
                        stepCnt  <= '0;
                        finePass <= ~finePass;
                    end
                end
                PH_DRAIN: begin
                    // two cycles so the last count reaches the peak table
                    if (stepCnt == STEP_W'(1)) begin
                        stepCnt <= '0;
                        // pass bit already flipped, set means coarse just ended
                        phase   <= finePass ? PH_FLUSH : PH_START;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                PH_FLUSH: begin
                    // one cycle per pixel for the coarse peak copy
                    if (stepCnt == STEP_W'(PIXELS - 1)) begin
                        stepCnt <= '0;
                        phase   <= PH_RUN;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                PH_START: phase <= PH_READOUT;
                PH_READOUT: begin
                    if (readoutDone) begin
                        phase <= PH_CLEAR;
                    end
                end
                PH_CLEAR: phase <= PH_RUN;
                default:  phase <= PH_RUN;
            endcase
        end
    end

endmodule

// ==== source/peakFinder.sv ====
module peakFinder
    import sifhPkg::*;
#(
    parameter int PIXELS  = 4,
    parameter int COUNT_W = 8,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               countValid,
    input  logic [PIX_W-1:0]   countPixel,
    input  logic [BIN_W-1:0]   countBin,
    input  logic [COUNT_W-1:0] countValue,
    input  logic               flush,
    input  logic               clearAll,
    input  logic [PIX_W-1:0]   readPixel,
    output logic [BIN_W-1:0]   peakBin,
    output logic [COUNT_W-1:0] peakMax
);

    // running max and its bin, per pixel
    logic [COUNT_W-1:0] maxTab [PIXELS];
    logic [BIN_W-1:0]   binTab [PIXELS];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXELS; i++) begin
                maxTab[i] <= '0;
                binTab[i] <= '0;
            end
        end else if (clearAll) begin
            for (int i = 0; i < PIXELS; i++) begin
                maxTab[i] <= '0;
                binTab[i] <= '0;
            end
        end else if (flush) begin
            // entry is cleared as the decoder copies it out
            maxTab[readPixel] <= '0;
            binTab[readPixel] <= '0;
        end else if (countValid && (countValue > maxTab[countPixel])) begin
            // strictly greater, so ties keep the earlier bin
            maxTab[countPixel] <= countValue;
            binTab[countPixel] <= countBin;
        end
    end

    assign peakBin = binTab[readPixel];
    assign peakMax = maxTab[readPixel];

endmodule

// ==== source/resultStreamer.sv ====
module resultStreamer
    import sifhPkg::*;
#(
    parameter int PIXELS  = 4,
    parameter int COUNT_W = 8,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                startReadout,
    input  logic [BIN_W-1:0]    peakBin,
    input  logic [COUNT_W-1:0]  peakMax,
    input  logic [COARSE_W-1:0] coarseBin,
    output logic [PIX_W-1:0]    readPixel,
    output logic                readoutDone,
    output logic                peakValid,
    output logic [PIX_W-1:0]    peakPixel,
    output logic [COARSE_W-1:0] peakCoarse,
    output logic [FINE_W-1:0]   peakFine,
    output logic [COUNT_W-1:0]  peakCount
);

    logic active;
    logic lastPixel;

    assign lastPixel = (readPixel == PIX_W'(PIXELS - 1));

    // pixel walk, one per cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            active      <= 1'b0;
            readPixel   <= '0;
            peakValid   <= 1'b0;
            readoutDone <= 1'b0;
        end else begin
            peakValid   <= active;
            // done comes out with the last result
            readoutDone <= active && lastPixel;
            if (startReadout) begin
                active    <= 1'b1;
                readPixel <= '0;
            end else if (active) begin
                active    <= !lastPixel;
                readPixel <= lastPixel ? '0 : readPixel + 1'b1;
            end
        end
    end

    // result word for the pixel being read
    always_ff @(posedge clk) begin
        if (active) begin
            peakPixel  <= readPixel;
            peakCoarse <= coarseBin;
            peakFine   <= peakBin[FINE_W-1:0];
            peakCount  <= peakMax;
        end
    end

endmodule

// ==== source/sampleDecoder.sv ====
module sampleDecoder
    import sifhPkg::*;
#(
    parameter int PIXELS = 4,
    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                clk,
    input  logic                combin_res,
    input  sampleWord_t         sample,
    input  logic [PIX_W-1:0]    pixel,
    input  logic                finePass,
    input  logic                flush,
    input  logic                clearAll,
    input  logic [BIN_W-1:0]    peakBin,
    input  logic [PIX_W-1:0]    readPixel,
    output logic [PIX_W-1:0]    peakPixelSel,
    output logic [COARSE_W-1:0] coarseBin,
    output logic [BIN_W-1:0]    binIdx,
    output logic                binHit
);

    // coarse peak per pixel, the fine pass window
    logic [COARSE_W-1:0] coarseStore [PIXELS];
    logic [PIX_W-1:0]    selCnt;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            selCnt <= '0;
            for (int i = 0; i < PIXELS; i++) begin
                coarseStore[i] <= '0;
            end
        end else if (clearAll) begin
            selCnt <= '0;
            for (int i = 0; i < PIXELS; i++) begin
                coarseStore[i] <= '0;
            end
        end else if (flush) begin
            // copy one pixel per flush cycle
            coarseStore[selCnt] <= peakBin[COARSE_W-1:0];
            selCnt <= (selCnt == PIX_W'(PIXELS - 1)) ? '0 : selCnt + 1'b1;
        end
    end

    // peak table index, ours while flushing, else the streamer's
    assign peakPixelSel = flush ? selCnt : readPixel;
    assign coarseBin    = coarseStore[readPixel];

    always_comb begin
        if (finePass) begin
            // only samples inside the coarse peak bin count
            binHit = (sample.field.coarse == coarseStore[pixel]);
            binIdx = BIN_W'(sample.field.fine);
        end else begin
            binHit = 1'b1;
            binIdx = BIN_W'(sample.field.coarse);
        end
    end

endmodule

// ==== source/sifhPkg.sv ====
package sifhPkg;

    // raw timing sample width
    localparam int SAMPLE_W = 12;

    // field widths from msb down
    localparam int COARSE_W  = 4;
    localparam int FINE_W    = 4;
    localparam int RESIDUE_W = SAMPLE_W - COARSE_W - FINE_W;

    // bin index wide enough for either pass
    localparam int BIN_W = (COARSE_W > FINE_W) ? COARSE_W : FINE_W;

    typedef struct packed {
        logic [COARSE_W-1:0]  coarse;
        logic [FINE_W-1:0]    fine;
        logic [RESIDUE_W-1:0] residue;
    } sampleFields_t;

    // same word seen raw or split into coarse, fine and residue
    typedef union packed {
        logic [SAMPLE_W-1:0] raw;
        sampleFields_t       field;
    } sampleWord_t;

endpackage

// ==== source/sifhTop.sv ====
module sifhTop
    import sifhPkg::*;
#(
    parameter int PIXELS  = 4,
    parameter int SAMPLES = 8,
    parameter int ACQS    = 2,
    parameter int COUNT_W = 8,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                clk,
    input  logic                combin_res,
    input  sampleWord_t         sample,
    input  logic                sampleValid,
    output logic                sampleReady,
    output logic                peakValid,
    output logic [PIX_W-1:0]    peakPixel,
    output logic [COARSE_W-1:0] peakCoarse,
    output logic [FINE_W-1:0]   peakFine,
    output logic [COUNT_W-1:0]  peakCount
);

    // sequencer controls
    logic               accept;
    logic [PIX_W-1:0]   pixel;
    logic               finePass;
    logic               flush;
    logic               startReadout;
    logic               clearAll;
    logic               readoutDone;

    // decoder to histogram
    logic [BIN_W-1:0]   binIdx;
    logic               binHit;

    // histogram to peak finder
    logic               countValid;
    logic [PIX_W-1:0]   countPixel;
    logic [BIN_W-1:0]   countBin;
    logic [COUNT_W-1:0] countValue;

    // peak table read side
    logic [PIX_W-1:0]    peakPixelSel;
    logic [PIX_W-1:0]    readPixel;
    logic [BIN_W-1:0]    peakBin;
    logic [COUNT_W-1:0]  peakMax;
    logic [COARSE_W-1:0] coarseBin;

    frameSequencer #(
        .PIXELS (PIXELS),
        .SAMPLES(SAMPLES),
        .ACQS   (ACQS)
    ) frameSequencer_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .readoutDone (readoutDone),
        .sampleReady (sampleReady),
        .accept      (accept),
        .pixel       (pixel),
        .finePass    (finePass),
        .flush       (flush),
        .startReadout(startReadout),
        .clearAll    (clearAll)
    );

    sampleDecoder #(
        .PIXELS(PIXELS)
    ) sampleDecoder_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .sample      (sample),
        .pixel       (pixel),
        .finePass    (finePass),
        .flush       (flush),
        .clearAll    (clearAll),
        .peakBin     (peakBin),
        .readPixel   (readPixel),
        .peakPixelSel(peakPixelSel),
        .coarseBin   (coarseBin),
        .binIdx      (binIdx),
        .binHit      (binHit)
    );

    binHistogram #(
        .PIXELS (PIXELS),
        .COUNT_W(COUNT_W)
    ) binHistogram_i (
        .clk       (clk),
        .combin_res(combin_res),
        .accept    (accept),
        .binHit    (binHit),
        .pixel     (pixel),
        .binIdx    (binIdx),
        .flush     (flush),
        .clearAll  (clearAll),
        .countValid(countValid),
        .countPixel(countPixel),
        .countBin  (countBin),
        .countValue(countValue)
    );

    peakFinder #(
        .PIXELS (PIXELS),
        .COUNT_W(COUNT_W)
    ) peakFinder_i (
        .clk       (clk),
        .combin_res(combin_res),
        .countValid(countValid),
        .countPixel(countPixel),
        .countBin  (countBin),
        .countValue(countValue),
        .flush     (flush),
        .clearAll  (clearAll),
        .readPixel (peakPixelSel),
        .peakBin   (peakBin),
        .peakMax   (peakMax)
    );

    resultStreamer #(
        .PIXELS (PIXELS),
        .COUNT_W(COUNT_W)
    ) resultStreamer_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .startReadout(startReadout),
        .peakBin     (peakBin),
        .peakMax     (peakMax),
        .coarseBin   (coarseBin),
        .readPixel   (readPixel),
        .readoutDone (readoutDone),
        .peakValid   (peakValid),
        .peakPixel   (peakPixel),
        .peakCoarse  (peakCoarse),
        .peakFine    (peakFine),
        .peakCount   (peakCount)
    );

endmodule

// ==== test/clockGen.sv ====
module clockGen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic combin_res
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        combin_res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
    end

endmodule

// ==== test/sifhTb.sv ====
module sifhTb
    import sifhPkg::*;
#(
    parameter int PIXELS  = 4,
    parameter int SAMPLES = 8,
    parameter int ACQS    = 2,
    parameter int COUNT_W = 8
) ();

    localparam int PIX_W   = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int TOTAL   = PIXELS * SAMPLES * ACQS;
    localparam int RES_W   = COARSE_W + FINE_W + COUNT_W;
    // directed, tie, window, two back to back, eight random
    localparam int FRAMES  = 13;
    localparam int TIMEOUT = FRAMES * (2 * TOTAL + PIXELS + 16) + 200;

    logic                clk;
    logic                combin_res;
    sampleWord_t         sample;
    logic                sampleValid;
    logic                sampleReady;
    logic                peakValid;
    logic [PIX_W-1:0]    peakPixel;
    logic [COARSE_W-1:0] peakCoarse;
    logic [FINE_W-1:0]   peakFine;
    logic [COUNT_W-1:0]  peakCount;

    // one frame as two passes in acq x pixel x sample order
    logic [SAMPLE_W-1:0] coarseSmp [TOTAL];
    logic [SAMPLE_W-1:0] fineSmp [TOTAL];

    // expected results in arrival order
    logic [RES_W-1:0] expQ [$];
    int               pixQ [$];

    string testName = "none";
    int    errCount = 0;
    int    errAtStart = 0;
    int    testsRun = 0;
    int    testsFailed = 0;
    int    cycleCnt = 0;

    clockGen #(
        .PERIOD      (10),
        .RESET_CYCLES(16)
    ) clockGen_i (
        .clk       (clk),
        .combin_res(combin_res)
    );

    sifhTop #(
        .PIXELS (PIXELS),
        .SAMPLES(SAMPLES),
        .ACQS   (ACQS),
        .COUNT_W(COUNT_W)
    ) sifhTop_i (
        .clk        (clk),
        .combin_res (combin_res),
        .sample     (sample),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakCoarse (peakCoarse),
        .peakFine   (peakFine),
        .peakCount  (peakCount)
    );

    function automatic logic [SAMPLE_W-1:0] makeWord(input int c, input int f, input int r);
        return {COARSE_W'(c), FINE_W'(f), RESIDUE_W'(r)};
    endfunction

    // expected coarse bin, fine bin and fine count of one pixel
    function automatic logic [RES_W-1:0] refPeak(input int pix);
        int cnt [2**BIN_W];
        int maxC;
        int peakC;
        int maxF;
        int peakF;
        int b;
        maxC  = 0;
        peakC = 0;
        maxF  = 0;
        peakF = 0;
        foreach (cnt[k]) cnt[k] = 0;
        for (int i = 0; i < TOTAL; i++) begin
            if ((i / SAMPLES) % PIXELS == pix) begin
                b = int'(coarseSmp[i][SAMPLE_W-1 -: COARSE_W]);
                cnt[b]++;
                // strictly above so a tie stays with the earlier bin
                if (cnt[b] > maxC) begin
                    maxC  = cnt[b];
                    peakC = b;
                end
            end
        end
        foreach (cnt[k]) cnt[k] = 0;
        for (int i = 0; i < TOTAL; i++) begin
            // fine window is the coarse peak bin
            if ((i / SAMPLES) % PIXELS == pix
                    && int'(fineSmp[i][SAMPLE_W-1 -: COARSE_W]) == peakC) begin
                b = int'(fineSmp[i][SAMPLE_W-COARSE_W-1 -: FINE_W]);
                cnt[b]++;
                if (cnt[b] > maxF) begin
                    maxF  = cnt[b];
                    peakF = b;
                end
            end
        end
        return {COARSE_W'(peakC), FINE_W'(peakF), COUNT_W'(maxF)};
    endfunction

    task automatic checkField(input string what, input int expV, input int actV);
        assert (actV == expV) else begin
            $display("Error %s %s: expected %0d, actual %0d", testName, what, expV, actV);
            errCount++;
        end
    endtask

    // one dominant coarse and fine bin per pixel that the offset moves
    task automatic buildDirected(input int offset);
        int p;
        int s;
        int cp;
        int fp;
        for (int i = 0; i < TOTAL; i++) begin
            p  = (i / SAMPLES) % PIXELS;
            s  = i % SAMPLES;
            cp = (3 * p + 5 + offset) % 16;
            fp = (5 * p + 2 + offset) % 16;
            coarseSmp[i] = makeWord((s % 4 == 3) ? (cp + 1) % 16 : cp, s, s);
            fineSmp[i]   = makeWord(cp, (s % 3 == 0) ? (fp + 7) % 16 : fp, s);
        end
    endtask

    // two bins alternate to equal counts and odd pixels start high
    task automatic buildTie();
        int p;
        int s;
        int cp;
        for (int i = 0; i < TOTAL; i++) begin
            p  = (i / SAMPLES) % PIXELS;
            s  = i % SAMPLES;
            cp = (p % 2 == 0) ? 2 : 11;
            coarseSmp[i] = makeWord(((s + p) % 2 == 0) ? 2 : 11, 0, s);
            fineSmp[i]   = makeWord(cp, ((s + p + 1) % 2 == 0) ? 7 : 3, s);
        end
    endtask

    // pixel 1 fine samples all miss its coarse peak
    task automatic buildOutOfWindow();
        int s;
        int cp;
        buildDirected(4);
        for (int i = 0; i < TOTAL; i++) begin
            s  = i % SAMPLES;
            cp = (3 + 5 + 4) % 16;
            if ((i / SAMPLES) % PIXELS == 1) begin
                fineSmp[i] = makeWord((cp + 1 + s) % 16, s, s);
            end
        end
    endtask

    // mostly from a small pool sharing two coarse values
    task automatic buildRandom();
        logic [SAMPLE_W-1:0] pool [4];
        int                  c0;
        c0 = int'($urandom_range(15, 0));
        foreach (pool[k]) begin
            pool[k] = makeWord((k < 2) ? c0 : (c0 + 1) % 16, int'($urandom_range(15, 0)),
                               int'($urandom_range(15, 0)));
        end
        for (int i = 0; i < TOTAL; i++) begin
            coarseSmp[i] = ($urandom_range(3, 0) != 0) ? pool[$urandom_range(3, 0)]
                                                       : SAMPLE_W'($urandom());
            fineSmp[i]   = ($urandom_range(3, 0) != 0) ? pool[$urandom_range(3, 0)]
                                                       : SAMPLE_W'($urandom());
        end
    endtask

    // drive on the falling edge and hold until an edge with ready
    task automatic sendSample(input logic [SAMPLE_W-1:0] word);
        @(negedge clk);
        sample.raw  = word;
        sampleValid = 1'b1;
        while (!sampleReady) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic runFrame(input bit hold);
        for (int p = 0; p < PIXELS; p++) begin
            expQ.push_back(refPeak(p));
            pixQ.push_back(p);
        end
        for (int i = 0; i < TOTAL; i++) begin
            sendSample(coarseSmp[i]);
        end
        for (int i = 0; i < TOTAL; i++) begin
            sendSample(fineSmp[i]);
        end
        // hold keeps valid up for the next frame
        if (!hold) begin
            @(negedge clk);
            sampleValid = 1'b0;
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        errAtStart = errCount;
    endtask

    // done once all results are in and the clear is over
    task automatic finishTest();
        int fails;
        while (expQ.size() != 0 || !sampleReady) @(negedge clk);
        fails = errCount - errAtStart;
        testsRun++;
        if (fails == 0) begin
            $display("test %s: passed", testName);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", testName, fails);
        end
    endtask

    // registered results sampled on the falling edge
    always @(negedge clk) begin
        logic [RES_W-1:0] expRes;
        int               expPix;
        if (combin_res && peakValid) begin
            assert (expQ.size() != 0) else begin
                $display("%s: result for pixel %0d came with none expected",
                         testName, peakPixel);
                errCount++;
            end
            if (expQ.size() != 0) begin
                expRes = expQ.pop_front();
                expPix = pixQ.pop_front();
                checkField("pixel", expPix, int'(peakPixel));
                checkField("coarse", int'(expRes[RES_W-1 -: COARSE_W]), int'(peakCoarse));
                checkField("fine", int'(expRes[COUNT_W +: FINE_W]), int'(peakFine));
                checkField("count", int'(expRes[COUNT_W-1:0]), int'(peakCount));
            end
        end
    end

    // limit covers every frame plus the gaps between passes
    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= TIMEOUT) begin
            $display("timeout after %0d cycles, results are missing", cycleCnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        sample      = '0;
        sampleValid = 1'b0;
        void'($urandom(32'hd70e));
        @(posedge combin_res);
        @(negedge clk);

        startTest("reset");
        checkField("sampleReady", 1, int'(sampleReady));
        checkField("peakValid", 0, int'(peakValid));
        finishTest();

        startTest("directed");
        buildDirected(0);
        runFrame(1'b0);
        finishTest();

        startTest("tie");
        buildTie();
        runFrame(1'b0);
        finishTest();

        startTest("outOfWindow");
        buildOutOfWindow();
        runFrame(1'b0);
        finishTest();

        // second frame waits behind the readout of the first
        startTest("backToBack");
        buildDirected(9);
        runFrame(1'b1);
        buildRandom();
        runFrame(1'b0);
        finishTest();

        for (int n = 0; n < 8; n++) begin
            startTest($sformatf("random%0d", n));
            buildRandom();
            runFrame(1'b0);
            finishTest();
        end

        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
